// File: verilog.f
+incdir+include
hdl/keyer_pkg.sv
hdl/keyer_regs.sv
hdl/element_timer.sv
hdl/iambic_keyer.sv
hdl/keyer_top.sv
verif/keyer_props.sv
verif/tb_keyer.sv

// File: verif/tb_keyer.sv
`timescale 1ns/1ps
`default_nettype none

`include "keyer_defines.svh"

module tb_keyer import keyer_pkg::*;
();

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 8;
    localparam int RUN_CYCLES   = 120 + 80 + 200 + 200 + 60 + 80 + 80;   // all paddle scripts
    localparam int AXI_OPS      = 24;
    localparam int AXI_OP_MAX   = 12;       // cycles per transfer, worst ready delay
    localparam int MARGIN       = 200;

    logic        clk;
    logic        rst_local;
    logic        dit;
    logic        dah;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        key;

    keyer_cfg_t  cfg_exp;                   // configuration as last written
    integer      seed;
    int          cyc;
    int          run_base;
    int          rise_at;
    logic        key_q;
    logic        cmp_req;
    string       test_name;
    int          exp_rise[$];
    int          exp_width[$];
    int          meas_rise[$];
    int          meas_width[$];
    logic [31:0] rd;

    keyer_top u_dut (
        .clk(clk), .rst_local(rst_local), .dit(dit), .dah(dah),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .key(key)
    );

    always #(PERIOD / 2) clk = ~clk;

    always @(posedge clk)
        cyc <= cyc + 1;

    // ======================================================================
    // checking and reference
    // ======================================================================
    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("FAIL at %0t ns, %s: %s is 0x%0h, expected 0x%0h",
                     $time, test_name, what, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    function automatic logic paddle_synced(input int on, input int off, input int n);
        return (n - 2 >= on) && (n - 2 < off);      // two flop synchronizer
    endfunction

    // expected marks of one paddle script, cycles relative to its first step
    function automatic void expect_marks(input keyer_cfg_t c, input int dit_on,
                                         input int dit_off, input int dah_on,
                                         input int dah_off, input int run_len);
        int   n;
        int   k;
        int   w;
        logic memo;
        logic last_dah;
        logic now_dah;
        exp_rise.delete();
        exp_width.delete();
        if (!c.enable)
            return;
        if (c.straight_key)
        begin
            if (dah_off > dah_on)
            begin
                exp_rise.push_back(dah_on + 2);
                exp_width.push_back(dah_off - dah_on);
            end
            return;
        end
        memo     = 1'b0;
        last_dah = 1'b0;
        n        = 0;
        while (n < run_len)
        begin
            if (!c.mode_b && !paddle_synced(dit_on, dit_off, n)
                && !paddle_synced(dah_on, dah_off, n))
            begin
                memo = 1'b0;                        // mode a drops memory on release
                n++;
            end
            else if ((c.mode_b && memo) || paddle_synced(dit_on, dit_off, n)
                     || paddle_synced(dah_on, dah_off, n))
            begin
                now_dah = memo ? !last_dah : paddle_synced(dah_on, dah_off, n);
                w       = now_dah ? 3 * c.dit_len : c.dit_len;
                memo    = 1'b0;
                for (k = n + 1; k <= n + w + c.dit_len; k++)
                    if (now_dah ? paddle_synced(dit_on, dit_off, k)
                                : paddle_synced(dah_on, dah_off, k))
                        memo = 1'b1;                // opposite paddle during mark or space
                exp_rise.push_back(n + 1);
                exp_width.push_back(w);
                last_dah = now_dah;
                n        = n + w + c.dit_len + 1;   // mark, space, idle cycle
            end
            else
                n++;
        end
    endfunction

    // key intervals sampled mid cycle
    always @(negedge clk)
    begin
        if (rst_local)
        begin
            if (key && !key_q)
                rise_at = cyc;
            if (!key && key_q)
            begin
                meas_rise.push_back(rise_at);
                meas_width.push_back(cyc - rise_at);
            end
            key_q = key;
        end
    end

    always
    begin
        wait (cmp_req);
        check_equal(meas_rise.size(), exp_rise.size(), "number of marks");
        foreach (exp_rise[i])
        begin
            check_equal(meas_rise[i] - run_base, exp_rise[i], "mark start cycle");
            check_equal(meas_width[i], exp_width[i], "mark length");
        end
        meas_rise.delete();
        meas_width.delete();
        cmp_req = 1'b0;
    end

    initial
    begin
        wait (u_dut.u_props.fail_count != 0);
        $display("a bound assertion on keying or AXI handshake rules failed");
        $display("Test failed");
        $fatal(1);
    end

    initial
    begin
        #((RESET_CYCLES + RUN_CYCLES + AXI_OPS * AXI_OP_MAX + MARGIN) * PERIOD);
        $display("watchdog timeout, the tests did not finish in the expected time");
        $display("Test failed");
        $fatal(1);
    end

    // ======================================================================
    // AXI4-Lite and paddle stimulus, all entered 2 ns after a rising edge
    // ======================================================================
    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        int delay;
        delay   = $unsigned($random(seed)) % 4;
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do
            @(negedge clk);
        while (!awready);
        check_equal(wready, 1'b1, "wready together with awready");
        @(posedge clk);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        repeat (delay)
        begin
            @(posedge clk);
            #2;
        end
        bready = 1'b1;                              // late bready
        do
            @(negedge clk);
        while (!bvalid);
        check_equal(bresp, 2'b00, "write response");
        @(posedge clk);
        #2;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
        int delay;
        delay   = $unsigned($random(seed)) % 4;
        araddr  = addr;
        arvalid = 1'b1;
        do
            @(negedge clk);
        while (!arready);
        @(posedge clk);
        #2;
        arvalid = 1'b0;
        repeat (delay)
        begin
            @(posedge clk);
            #2;
        end
        rready = 1'b1;
        do
            @(negedge clk);
        while (!rvalid);
        data = rdata;
        check_equal(rresp, 2'b00, "read response");
        @(posedge clk);
        #2;
        rready = 1'b0;
    endtask

    task automatic set_ctrl(input logic en, input logic mb, input logic sk);
        axi_write(`KEYER_ADDR_CTRL, {24'd0, en, 5'd0, sk, mb}, 4'hf);
        cfg_exp.enable       = en;
        cfg_exp.mode_b       = mb;
        cfg_exp.straight_key = sk;
    endtask

    task automatic run_script(input string name, input int dit_on, input int dit_off,
                              input int dah_on, input int dah_off, input int run_len);
        int s;
        test_name = name;
        run_base  = cyc;
        for (s = 0; s < run_len; s++)
        begin
            dit = (s >= dit_on) && (s < dit_off);
            dah = (s >= dah_on) && (s < dah_off);
            @(posedge clk);
            #2;
        end
        expect_marks(cfg_exp, dit_on, dit_off, dah_on, dah_off, run_len);
        cmp_req = 1'b1;
        wait (!cmp_req);
    endtask

    initial
    begin
        clk       = 1'b0;
        rst_local = 1'b0;
        dit       = 1'b0;
        dah       = 1'b0;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        seed      = 32'hf3a1;
        cyc       = 0;
        key_q     = 1'b0;
        cmp_req   = 1'b0;
        test_name = "register access";
        cfg_exp.enable       = 1'b1;
        cfg_exp.mode_b       = 1'b1;
        cfg_exp.straight_key = 1'b0;
        cfg_exp.dit_len      = 16'd64;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_local = 1'b1;

        axi_read(`KEYER_ADDR_CTRL, rd);
        check_equal(rd, 32'h81, "CTRL after reset");
        axi_read(`KEYER_ADDR_DIT_LEN, rd);
        check_equal(rd, 32'd64, "DIT_LEN after reset");
        axi_write(`KEYER_ADDR_DIT_LEN, 32'd10, 4'hf);
        axi_read(`KEYER_ADDR_DIT_LEN, rd);
        check_equal(rd, 32'd10, "DIT_LEN readback");
        axi_write(`KEYER_ADDR_DIT_LEN, 32'h1234, 4'h1);    // low byte lane only
        axi_read(`KEYER_ADDR_DIT_LEN, rd);
        check_equal(rd, 32'h34, "DIT_LEN byte strobe");
        axi_write(`KEYER_ADDR_DIT_LEN, 32'd10, 4'hf);
        cfg_exp.dit_len = 16'd10;
        axi_write(`KEYER_ADDR_CTRL, 32'hffff_ff80, 4'hf);  // enable, mode a
        cfg_exp.mode_b = 1'b0;
        axi_read(`KEYER_ADDR_CTRL, rd);
        check_equal(rd, 32'h80, "CTRL readback");
        axi_write(`KEYER_ADDR_STATUS, 32'hffff_ffff, 4'hf);
        axi_read(`KEYER_ADDR_STATUS, rd);
        check_equal(rd, 32'h0, "STATUS after write");
        axi_read(`KEYER_ADDR_CTRL, rd);
        check_equal(rd, 32'h80, "CTRL after STATUS write");
        axi_write(4'hc, 32'hffff_ffff, 4'hf);
        axi_read(4'hc, rd);
        check_equal(rd, 32'h0, "unmapped address");

        run_script("held dit", 0, 45, 0, 0, 120);
        run_script("held dah", 0, 0, 0, 20, 80);
        run_script("squeeze mode a", 0, 68, 4, 68, 200);
        set_ctrl(1'b1, 1'b1, 1'b0);
        run_script("squeeze mode b", 0, 68, 4, 68, 200);
        set_ctrl(1'b1, 1'b1, 1'b1);
        run_script("straight key", 5, 30, 10, 25, 60);
        set_ctrl(1'b0, 1'b1, 1'b0);
        run_script("keyer disabled", 0, 40, 10, 50, 80);
        set_ctrl(1'b1, 1'b1, 1'b0);
        run_script("keyer enabled again", 0, 25, 0, 0, 80);

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/keyer_props.sv
`timescale 1ns/1ps
`default_nettype none

module keyer_props import keyer_pkg::*;
(
    input logic          clk,
    input logic          rst_local,
    input keyer_cfg_t    cfg,
    input keyer_status_t status,
    input logic          key,
    input logic          bvalid,
    input logic          bready,
    input logic          rvalid,
    input logic          rready
);

    int          fail_count = 0;    // failed assertions so far
    logic [17:0] mark_cnt;          // cycles spent in the current mark

    always_ff @(posedge clk or negedge rst_local)
    begin
        if (!rst_local)
            mark_cnt <= '0;
        else if (status.state == KS_MARK)
            mark_cnt <= mark_cnt + 18'd1;
        else
            mark_cnt <= '0;
    end

    // ======================================================================
    // keying rules
    // ======================================================================
    key_off_when_disabled: assert property (@(posedge clk) disable iff (!rst_local)
        (!cfg.enable && !cfg.straight_key) |-> !key ##1 (status.state == KS_IDLE))
    else
    begin
        $error("key high or element still running while the keyer is disabled");
        fail_count++;
    end

    mark_min_length: assert property (@(posedge clk) disable iff (!rst_local)
        ((mark_cnt != 0) && (status.state != KS_MARK) && cfg.enable && !cfg.straight_key)
        |-> (mark_cnt >= cfg.dit_len))
    else
    begin
        $error("mark ended after %0d cycles, shorter than one dit", mark_cnt);
        fail_count++;
    end

    // ======================================================================
    // AXI4-Lite response channels
    // ======================================================================
    bvalid_held: assert property (@(posedge clk) disable iff (!rst_local)
        (bvalid && !bready) |=> bvalid)
    else
    begin
        $error("bvalid dropped before bready");
        fail_count++;
    end

    rvalid_held: assert property (@(posedge clk) disable iff (!rst_local)
        (rvalid && !rready) |=> rvalid)
    else
    begin
        $error("rvalid dropped before rready");
        fail_count++;
    end

endmodule

bind keyer_top keyer_props u_props (
    .clk(clk), .rst_local(rst_local), .cfg(cfg), .status(status), .key(key),
    .bvalid(bvalid), .bready(bready), .rvalid(rvalid), .rready(rready)
);

`default_nettype wire

// File: hdl/keyer_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "keyer_defines.svh"

module keyer_top import keyer_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_local,
    input  logic                      dit,
    input  logic                      dah,
    input  logic [`KEYER_AXI_AW-1:0]  awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [`KEYER_AXI_DW-1:0]  wdata,
    input  logic [3:0]                wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [`KEYER_AXI_AW-1:0]  araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [`KEYER_AXI_DW-1:0]  rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready,
    output logic                      key
);

    keyer_cfg_t    cfg;
    keyer_status_t status;
    timer_cmd_t    cmd;
    logic          done;

    keyer_regs u_regs (
        .clk(clk), .rst_local(rst_local),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .status(status), .cfg(cfg)
    );

    iambic_keyer u_keyer (
        .clk(clk), .rst_local(rst_local), .dit(dit), .dah(dah),
        .cfg(cfg), .done(done), .cmd(cmd), .status(status), .key(key)
    );

    element_timer u_timer (
        .clk(clk), .rst_local(rst_local), .cfg(cfg), .cmd(cmd), .done(done)
    );

endmodule

`default_nettype wire

// File: hdl/iambic_keyer.sv
`timescale 1ns/1ps
`default_nettype none

module iambic_keyer import keyer_pkg::*;
(
    input  logic          clk,
    input  logic          rst_local,
    input  logic          dit,
    input  logic          dah,
    input  keyer_cfg_t    cfg,
    input  logic          done,
    output timer_cmd_t    cmd,
    output keyer_status_t status,
    output logic          key
);

    logic [1:0]   dit_ff;
    logic [1:0]   dah_ff;
    logic         dit_sync;
    logic         dah_sync;
    keyer_state_e state;
    logic         is_dah;               // current element is a dah
    logic         iamb;                 // opposite paddle seen
    logic         held;
    logic         want_el;
    logic         next_dah;
    logic         opposite;

    // ==================================================================
    // paddle synchronizers
    // ==================================================================
    always_ff @(posedge clk or negedge rst_local)
    begin
        if (!rst_local)
        begin
            dit_ff <= 2'b00;
            dah_ff <= 2'b00;
        end
        else
        begin
            dit_ff <= {dit_ff[0], dit};
            dah_ff <= {dah_ff[0], dah};
        end
    end

    assign dit_sync = dit_ff[1];
    assign dah_sync = dah_ff[1];

    // ==================================================================
    // element FSM
    // ==================================================================
    assign held     = !cfg.enable || cfg.straight_key;         // keep FSM in idle
    assign want_el  = (cfg.mode_b && iamb) || dit_sync || dah_sync;
    assign next_dah = iamb ? !is_dah : dah_sync;               // alternate on a squeeze
    assign opposite = is_dah ? dit_sync : dah_sync;

    always_ff @(posedge clk or negedge rst_local)
    begin
        if (!rst_local)
        begin
            state  <= KS_IDLE;
            is_dah <= 1'b0;
            iamb   <= 1'b0;
        end
        else if (held)
        begin
            state <= KS_IDLE;
            iamb  <= 1'b0;
        end
        else
        begin
            case (state)
                KS_IDLE:
                begin
                    if (!cfg.mode_b && !dit_sync && !dah_sync)
                        iamb <= 1'b0;               // mode a forgets on release
                    else if (want_el)
                    begin
                        state  <= KS_MARK;
                        is_dah <= next_dah;
                        iamb   <= 1'b0;
                    end
                end
                KS_MARK:
                begin
                    if (opposite)
                        iamb <= 1'b1;
                    if (done)
                        state <= KS_SPACE;
                end
                KS_SPACE:
                begin
                    if (opposite)
                        iamb <= 1'b1;
                    if (done)
                        state <= KS_IDLE;
                end
                default: state <= KS_IDLE;
            endcase
        end
    end

    // timer is started together with each state entry
    always_comb
    begin
        cmd.start = 1'b0;
        cmd.units = 2'd1;
        if (!held && state == KS_IDLE && want_el)
        begin
            cmd.start = 1'b1;
            cmd.units = next_dah ? 2'd3 : 2'd1;     // dah is three units
        end
        else if (!held && state == KS_MARK && done)
            cmd.start = 1'b1;                       // one unit space
    end

    assign key = cfg.enable && (cfg.straight_key ? dah_sync : (state == KS_MARK));

    assign status.key      = key;
    assign status.dit_sync = dit_sync;
    assign status.dah_sync = dah_sync;
    assign status.is_dah   = is_dah;
    assign status.state    = state;

endmodule

`default_nettype wire

// File: hdl/element_timer.sv
`timescale 1ns/1ps
`default_nettype none

module element_timer import keyer_pkg::*;
(
    input  logic       clk,
    input  logic       rst_local,
    input  keyer_cfg_t cfg,
    input  timer_cmd_t cmd,
    output logic       done
);

    logic [15:0] cycle_cnt;             // cycles left in the current unit
    logic [1:0]  unit_cnt;              // units left, zero when stopped
    logic        last_cycle;

    // a dit_len of zero behaves as one
    assign last_cycle = (cycle_cnt <= 16'd1);
    assign done       = (unit_cnt == 2'd1) && last_cycle;

    always_ff @(posedge clk or negedge rst_local)
    begin
        if (!rst_local)
        begin
            cycle_cnt <= '0;
            unit_cnt  <= '0;
        end
        else if (!cfg.enable)
        begin
            cycle_cnt <= '0;
            unit_cnt  <= '0;
        end
        else if (cmd.start)                         // also restarts a running count
        begin
            cycle_cnt <= cfg.dit_len;
            unit_cnt  <= cmd.units;
        end
        else if (unit_cnt != 2'd0)
        begin
            if (last_cycle)
            begin
                cycle_cnt <= cfg.dit_len;           // next unit
                unit_cnt  <= unit_cnt - 2'd1;
            end
            else
                cycle_cnt <= cycle_cnt - 16'd1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/keyer_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "keyer_defines.svh"

module keyer_regs import keyer_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_local,
    input  logic [`KEYER_AXI_AW-1:0]  awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [`KEYER_AXI_DW-1:0]  wdata,
    input  logic [3:0]                wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [`KEYER_AXI_AW-1:0]  araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [`KEYER_AXI_DW-1:0]  rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready,
    input  keyer_status_t             status,
    output keyer_cfg_t                cfg
);

    localparam logic [7:0] CTRL_RST = `KEYER_CTRL_RST;

    keyer_reg_e wr_sel;
    keyer_reg_e rd_sel;
    logic       wr_hs;
    logic       rd_hs;

    function automatic keyer_reg_e decode(input logic [`KEYER_AXI_AW-1:0] addr);
        case (addr)
            `KEYER_ADDR_CTRL:    decode = REG_CTRL;
            `KEYER_ADDR_DIT_LEN: decode = REG_DIT_LEN;
            `KEYER_ADDR_STATUS:  decode = REG_STATUS;
            default:             decode = REG_NONE;
        endcase
    endfunction

    assign wr_sel = decode(awaddr);
    assign rd_sel = decode(araddr);
    assign wr_hs  = awready && awvalid && wvalid;
    assign rd_hs  = arready && arvalid;
    assign bresp  = 2'b00;                                  // always OKAY
    assign rresp  = 2'b00;

    // ==================================================================
    // write channel
    // ==================================================================
    always_ff @(posedge clk or negedge rst_local)
    begin
        if (!rst_local)
        begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end
        else
        begin
            awready <= awvalid && wvalid && !bvalid && !awready;    // one cycle pulse
            wready  <= awvalid && wvalid && !bvalid && !awready;
            if (wr_hs)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_local)
    begin
        if (!rst_local)
        begin
            cfg.mode_b       <= CTRL_RST[0];
            cfg.straight_key <= CTRL_RST[1];
            cfg.enable       <= CTRL_RST[7];
            cfg.dit_len      <= `KEYER_DIT_LEN_RST;
        end
        else if (wr_hs)
        begin
            if (wr_sel == REG_CTRL && wstrb[0])
            begin
                cfg.mode_b       <= wdata[0];
                cfg.straight_key <= wdata[1];
                cfg.enable       <= wdata[7];
            end
            if (wr_sel == REG_DIT_LEN)
            begin
                if (wstrb[0])
                    cfg.dit_len[7:0]  <= wdata[7:0];
                if (wstrb[1])
                    cfg.dit_len[15:8] <= wdata[15:8];
            end
        end
    end

    // ==================================================================
    // read channel
    // ==================================================================
    always_ff @(posedge clk or negedge rst_local)
    begin
        if (!rst_local)
        begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end
        else
        begin
            arready <= arvalid && !rvalid && !arready;
            if (rd_hs)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_hs)
        begin
            case (rd_sel)
                REG_CTRL:    rdata <= {24'd0, cfg.enable, 5'd0, cfg.straight_key, cfg.mode_b};
                REG_DIT_LEN: rdata <= {16'd0, cfg.dit_len};
                REG_STATUS:  rdata <= {{(`KEYER_AXI_DW - $bits(keyer_status_t)){1'b0}}, status};
                default:     rdata <= '0;               // unmapped reads as zero
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/keyer_pkg.sv
`default_nettype none

package keyer_pkg;

    // configuration from the register block
    typedef struct packed {
        logic        enable;
        logic        mode_b;
        logic        straight_key;
        logic [15:0] dit_len;           // cycles per dit unit
    } keyer_cfg_t;

    typedef enum logic [1:0] {
        KS_IDLE  = 2'd0,
        KS_MARK  = 2'd1,
        KS_SPACE = 2'd2
    } keyer_state_e;

    // readable through STATUS
    typedef struct packed {
        logic         key;
        logic         dit_sync;
        logic         dah_sync;
        logic         is_dah;
        keyer_state_e state;
    } keyer_status_t;

    typedef enum logic [1:0] {
        REG_CTRL, REG_DIT_LEN, REG_STATUS, REG_NONE
    } keyer_reg_e;

    typedef struct packed {
        logic       start;              // single cycle
        logic [1:0] units;              // 1 for dit or space, 3 for dah
    } timer_cmd_t;

endpackage

`default_nettype wire

// File: include/keyer_defines.svh
`ifndef KEYER_DEFINES_SVH
`define KEYER_DEFINES_SVH

// ======================================================================
// AXI4-Lite bus widths
// ======================================================================
`define KEYER_AXI_DW 32                 // data width
`define KEYER_AXI_AW 4                  // byte address width

// ======================================================================
// register map, byte addresses
// ======================================================================
`define KEYER_ADDR_CTRL    4'h0         // enable, mode_b, straight_key
`define KEYER_ADDR_DIT_LEN 4'h4         // dit unit in clock cycles
`define KEYER_ADDR_STATUS  4'h8         // read only

// reset values
`define KEYER_CTRL_RST     8'h81        // enable and mode b
`define KEYER_DIT_LEN_RST  16'd64

`endif
